//--- Bender.yml
package:
  name: ps2_key

export_include_dirs:
  - common

sources:
  - files:
      - common/ps2_pkg.sv
      - ps2_rx/ps2_rx.sv
      - hdl/key_decoder.sv
      - hdl/seg_display.sv
      - hdl/ps2_key_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/ps2_key_chk.sv
      - test/ps2_key_tb.sv

//--- common/ps2_consts.svh
`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

// Prefix bytes of the scan code set 2.
`define PS2_BREAK_CODE 8'hF0
`define PS2_EXT_CODE 8'hE0

// Flip-flops on each keyboard line.
`define PS2_SYNC_STAGES 2

// Start, 8 data, parity and stop.
`define PS2_FRAME_BITS 11

// Idle counter width, its terminal count drops a partial frame.
// At 50 MHz this is about 1.3 ms, well above one bit period.
`define PS2_IDLE_CNT_W 16

`endif

//--- common/ps2_pkg.sv
package ps2_pkg;

    // One byte as sent by the keyboard.
    typedef logic [7:0] scan_code_t;

    // Decoder prefix tracking.
    typedef enum logic [1:0]
    {
        KEY_IDLE  = 2'd0, // No prefix pending.
        KEY_EXT   = 2'd1, // E0 seen.
        KEY_BREAK = 2'd2  // F0 seen, next byte releases the key.
    } key_state_t;

endpackage

//--- hdl/key_decoder.sv
`timescale 1ns/1ns
`include "ps2_consts.svh"

module key_decoder
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  scan_code_t data,
    input  logic       ready,
    output logic       next_n,
    output scan_code_t key,
    output logic       blank
);

    key_state_t state;
    logic       is_ext;
    logic       is_break;

    // Every byte is consumed on the cycle it shows up.
    assign next_n = ~ready;

    assign is_ext   = (data == `PS2_EXT_CODE);
    assign is_break = (data == `PS2_BREAK_CODE);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= KEY_IDLE;
            key   <= '0;
            blank <= 1'b1;
        end
        else if (ready)
        begin
            unique case (state)
                KEY_IDLE, KEY_EXT:
                begin
                    if (is_ext)
                    begin
                        state <= KEY_EXT;
                    end
                    else if (is_break)
                    begin
                        state <= KEY_BREAK;
                    end
                    else
                    begin
                        // Make code.
                        key   <= data;
                        blank <= 1'b0;
                        state <= KEY_IDLE;
                    end
                end
                KEY_BREAK:
                begin
                    // Released key, keep the old code latched.
                    blank <= 1'b1;
                    state <= KEY_IDLE;
                end
                default:
                begin
                    state <= KEY_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/ps2_key_top.sv
`timescale 1ns/1ns

module ps2_key_top
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] seg_lo,
    output logic [7:0] seg_hi
);

    scan_code_t rx_data;
    logic       rx_ready;
    logic       rx_next_n;
    scan_code_t key;
    logic       blank;

    ps2_rx ps2_rx_inst
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .next_n  (rx_next_n),
        .data    (rx_data),
        .ready   (rx_ready)
    );

    key_decoder key_decoder_inst
    (
        .clk    (clk),
        .rst    (rst),
        .data   (rx_data),
        .ready  (rx_ready),
        .next_n (rx_next_n),
        .key    (key),
        .blank  (blank)
    );

    seg_display seg_display_inst
    (
        .clk    (clk),
        .rst    (rst),
        .key    (key),
        .blank  (blank),
        .seg_lo (seg_lo),
        .seg_hi (seg_hi)
    );

endmodule

//--- hdl/seg_display.sv
`timescale 1ns/1ns

module seg_display
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  scan_code_t key,
    input  logic       blank,
    output logic [7:0] seg_lo,
    output logic [7:0] seg_hi
);

    // Bit 7 is the point, bits 6:0 are g down to a. All active low.
    function automatic logic [7:0] hex_to_seg(input logic [3:0] nib);
        logic [7:0] seg;
        unique case (nib)
            4'h0: seg = 8'hC0;
            4'h1: seg = 8'hF9;
            4'h2: seg = 8'hA4;
            4'h3: seg = 8'hB0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hF8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'hA: seg = 8'h88;
            4'hB: seg = 8'h83;
            4'hC: seg = 8'hC6;
            4'hD: seg = 8'hA1;
            4'hE: seg = 8'h86;
            default: seg = 8'h8E; // F.
        endcase
        return seg;
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst || blank)
        begin
            seg_lo <= '1; // All segments dark.
            seg_hi <= '1;
        end
        else
        begin
            seg_lo <= hex_to_seg(key[3:0]);
            seg_hi <= hex_to_seg(key[7:4]);
        end
    end

endmodule

//--- ps2_rx/ps2_rx.sv
`timescale 1ns/1ns
`include "ps2_consts.svh"

module ps2_rx
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    input  logic       next_n,
    output scan_code_t data,
    output logic       ready
);

    localparam int SYNC = `PS2_SYNC_STAGES;
    localparam int FRAME_BITS = `PS2_FRAME_BITS;
    localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 1);

    logic [SYNC-1:0]            clk_sync;
    logic [SYNC-1:0]            dat_sync;
    logic                       clk_last;
    logic                       clk_s;
    logic                       dat_s;
    logic                       clk_fall;
    logic [3:0]                 bit_cnt;
    logic [FRAME_BITS-1:0]      frame;
    logic                       frame_done;
    logic                       frame_ok;
    logic [`PS2_IDLE_CNT_W-1:0] idle_cnt;
    logic                       idle_timeout;

    // Both lines idle high.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_last <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC-2:0], ps2_dat};
            clk_last <= clk_s;
        end
    end

    assign clk_s = clk_sync[SYNC-1];
    assign dat_s = dat_sync[SYNC-1];
    assign clk_fall = clk_last & ~clk_s;

    // Bits arrive LSB first, so shift in from the top.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt    <= '0;
            frame      <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (clk_fall)
            begin
                frame <= {dat_s, frame[FRAME_BITS-1:1]};
                if (bit_cnt == LAST_BIT)
                begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1; // Stop bit taken.
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else if (idle_timeout)
            begin
                bit_cnt <= '0; // Lost sync, wait for a new start bit.
            end
        end
    end

    // Runs only while a frame is partly received.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            idle_cnt <= '0;
        end
        else if (clk_fall || bit_cnt == '0)
        begin
            idle_cnt <= '0;
        end
        else if (!idle_timeout)
        begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign idle_timeout = &idle_cnt;

    // Start low, stop high, odd parity over data and parity bit.
    assign frame_ok = ~frame[0] & frame[FRAME_BITS-1] & (^frame[9:1]);

    always_ff @(posedge clk)
    begin
        if (frame_done && frame_ok)
        begin
            data <= frame[8:1];
        end
    end

    // A new byte wins over a pop in the same cycle.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            ready <= 1'b0;
        end
        else if (frame_done && frame_ok)
        begin
            ready <= 1'b1;
        end
        else if (!next_n)
        begin
            ready <= 1'b0;
        end
    end

endmodule

//--- tb.f
+incdir+common
common/ps2_pkg.sv
ps2_rx/ps2_rx.sv
hdl/key_decoder.sv
hdl/seg_display.sv
hdl/ps2_key_top.sv
test/ps2_key_chk.sv
test/ps2_key_tb.sv

//--- test/ps2_key_chk.sv
`timescale 1ns/1ns
`include "ps2_consts.svh"

module ps2_key_chk
    import ps2_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       ps2_clk,
    input logic       ready,
    input logic       next_n,
    input key_state_t state,
    input logic       blank,
    input logic [7:0] seg_lo,
    input logic [7:0] seg_hi
);

    int fail_cnt = 0;

    pop_clears_ready: assert property (@(posedge clk) disable iff (!rst) !next_n |=> !ready)
    else
    begin
        $error("ready still high one cycle after a pop");
        fail_cnt++;
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst) !ready |-> next_n)
    else
    begin
        $error("next_n low while no byte is held");
        fail_cnt++;
    end

    pop_one_cycle: assert property (@(posedge clk) disable iff (!rst) !next_n |=> next_n)
    else
    begin
        $error("next_n low for more than one cycle");
        fail_cnt++;
    end

    // A byte shows up only after the keyboard clock went low through the synchronizer.
    ready_after_edge: assert property (@(posedge clk) disable iff (!rst)
        $rose(ready) |-> !$past(ps2_clk, `PS2_SYNC_STAGES + 1))
    else
    begin
        $error("ready rose without a keyboard clock edge");
        fail_cnt++;
    end

    // Only the byte after a break prefix darkens the display.
    release_blanks: assert property (@(posedge clk) disable iff (!rst)
        $rose(blank) |-> $past(state == KEY_BREAK && !next_n))
    else
    begin
        $error("display blanked without a break sequence");
        fail_cnt++;
    end

    reset_dark: assert property (@(posedge clk) !rst |=> (seg_lo == 8'hFF && seg_hi == 8'hFF))
    else
    begin
        $error("segments lit after reset");
        fail_cnt++;
    end

endmodule

bind ps2_key_top ps2_key_chk ps2_key_chk_inst
(
    .clk     (clk),
    .rst     (rst),
    .ps2_clk (ps2_clk),
    .ready   (rx_ready),
    .next_n  (rx_next_n),
    .state   (key_decoder_inst.state),
    .blank   (blank),
    .seg_lo  (seg_lo),
    .seg_hi  (seg_hi)
);

//--- test/ps2_key_tb.sv
`timescale 1ns/1ns
`include "ps2_consts.svh"

module ps2_key_tb
    import ps2_pkg::*;
();

    localparam int POP_TIMEOUT = 2000;

    // Active low, point off, digit F in the top byte down to digit 0.
    localparam logic [127:0] SEG_ROM = {
        8'h8E, 8'h86, 8'hA1, 8'hC6, 8'h83, 8'h88, 8'h90, 8'h80,
        8'hF8, 8'h82, 8'h92, 8'h99, 8'hB0, 8'hA4, 8'hF9, 8'hC0
    };

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_dat;
    logic [7:0]  seg_lo;
    logic [7:0]  seg_hi;
    logic [31:0] lfsr;
    int          pops;
    int          errors;
    int          checks;
    int          test_errs;
    int          target;
    int          total;
    scan_code_t  held;
    scan_code_t  code;

    ps2_key_top ps2_key_top_inst
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg_lo  (seg_lo),
        .seg_hi  (seg_hi)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Bytes taken by the decoder.
    always @(posedge clk)
    begin
        if (rst && !ps2_key_top_inst.rx_next_n)
        begin
            pops <= pops + 1;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] seg_of(input logic [3:0] nib);
        return SEG_ROM[{nib, 3'b000} +: 8];
    endfunction

    // Prefix bytes are drawn again.
    task automatic random_code(output scan_code_t c);
        scan_code_t v;
        int i;
        v = `PS2_EXT_CODE;
        while (v == `PS2_EXT_CODE || v == `PS2_BREAK_CODE)
        begin
            for (i = 0; i < 8; i++)
            begin
                v[i] = lfsr[0];
                lfsr = lfsr_step(lfsr);
            end
        end
        c = v;
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input scan_code_t c, input logic bad_parity);
        logic [10:0] bits;
        int i;
        bits = {1'b1, ~(^c) ^ bad_parity, c, 1'b0}; // Stop, odd parity, data, start.
        tick(1);
        for (i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            tick(20);
            ps2_clk = 1'b0;
            tick(20);
            ps2_clk = 1'b1;
        end
        tick(40);
    endtask

    task automatic wait_pop(input int goal);
        int n;
        n = 0;
        while (pops < goal && n < POP_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (pops < goal)
        begin
            $display("Timed out at %0t ns waiting for the decoder to take a byte", $time);
            $display("test failed");
            $finish;
        end
        repeat (2) @(posedge clk); // Decoder, then display register.
        @(negedge clk);
    endtask

    task automatic send_byte(input scan_code_t c);
        int goal;
        goal = pops + 1;
        send_frame(c, 1'b0);
        wait_pop(goal);
    endtask

    task automatic check_display(input logic dark, input scan_code_t c);
        logic [7:0] exp_lo;
        logic [7:0] exp_hi;
        exp_lo = dark ? 8'hFF : seg_of(c[3:0]);
        exp_hi = dark ? 8'hFF : seg_of(c[7:4]);
        checks++;
        assert (seg_lo === exp_lo && seg_hi === exp_hi)
        else
        begin
            $display("** Error at %0t ns: display %h %h, expected %h %h for code %h",
                $time, seg_hi, seg_lo, exp_hi, exp_lo, c);
            errors++;
        end
    endtask

    task automatic report(input string name);
        $display("%-10s %s", name, (errors == test_errs) ? "ok" : "with errors");
        test_errs = errors;
    endtask

    initial
    begin
        rst       = 1'b0;
        ps2_clk   = 1'b1;
        ps2_dat   = 1'b1;
        lfsr      = 32'hf79f_bf07;
        pops      = 0;
        errors    = 0;
        checks    = 0;
        test_errs = 0;
        tick(3);
        rst = 1'b1;
        @(negedge clk);
        check_display(1'b1, 8'h00);
        report("reset");

        repeat (8)
        begin
            random_code(code);
            send_byte(code);
            check_display(1'b0, code);
        end
        held = code;
        report("make");

        send_byte(`PS2_BREAK_CODE);
        send_byte(held);
        check_display(1'b1, held);
        random_code(code);
        send_byte(code);
        check_display(1'b0, code);
        held = code;
        report("break");

        random_code(code);
        target = pops;
        send_frame(code, 1'b1);
        @(negedge clk);
        checks++;
        assert (pops == target)
        else
        begin
            $display("** Error at %0t ns: frame with bad parity reached the decoder", $time);
            errors++;
        end
        check_display(1'b0, held); // Still the old key.
        send_byte(code);
        check_display(1'b0, code);
        report("parity");

        random_code(code);
        send_byte(`PS2_EXT_CODE);
        send_byte(code);
        check_display(1'b0, code);
        send_byte(`PS2_EXT_CODE);
        send_byte(`PS2_BREAK_CODE);
        send_byte(code);
        check_display(1'b1, code);
        report("extended");

        total = errors + ps2_key_top_inst.ps2_key_chk_inst.fail_cnt;
        $display("checks %0d, check errors %0d, assertion errors %0d",
            checks, errors, ps2_key_top_inst.ps2_key_chk_inst.fail_cnt);
        if (total == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule
